//--- Makefile
# Verilator build and run for the packet path testbench

TOP       ?= proxy_pkt_tb
FLIST     ?= proxy_pkt.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Finished with errors

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/packet_capture.sv
`timescale 1ns/1ps

module packet_capture import proxy_pkt_pkg::*; (
    input  logic           clk,
    input  logic           srst,
    input  pkt_word_t      i_word,
    output capture_stats_t o_stats
);
    pkt_len_t run_len;
    pkt_len_t cur_len;

    // Word position inside the current packet, restarts at sop
    assign cur_len = (i_word.sop ? pkt_len_t'(0) : run_len) + 1'b1;

    always_ff @(posedge clk) begin
        if (srst) begin
            o_stats <= '0;
            run_len <= '0;
        end else if (i_word.valid) begin
            o_stats.word_count <= o_stats.word_count + 1'b1;
            // Checksum wraps modulo 2^32
            o_stats.checksum   <= o_stats.checksum + i_word.data;
            run_len            <= cur_len;
            if (i_word.eop) begin
                o_stats.pkt_count <= o_stats.pkt_count + 1'b1;
                o_stats.last_len  <= cur_len;
            end
        end
    end

endmodule

//--- hdl/packet_desc_fifo.sv
`timescale 1ns/1ps

module packet_desc_fifo import proxy_pkt_pkg::*; #(
    parameter int DESC_DEPTH = 4
) (
    input  logic  clk,
    input  logic  srst,
    input  logic  i_push,
    input  desc_t i_desc,
    input  logic  i_pop,
    output desc_t o_desc,
    output logic  o_empty,
    output logic  o_full
);
    localparam int PTR_WID = (DESC_DEPTH > 1) ? $clog2(DESC_DEPTH) : 1;
    localparam int CNT_WID = $clog2(DESC_DEPTH + 1);

    desc_t              entries [DESC_DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               push_ok;
    logic               pop_ok;

    assign push_ok = i_push && !o_full;
    assign pop_ok  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) wr_ptr <= (wr_ptr == PTR_WID'(DESC_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok) rd_ptr <= (rd_ptr == PTR_WID'(DESC_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_WID'(push_ok) - CNT_WID'(pop_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) entries[wr_ptr] <= i_desc;
    end

    // Head entry is visible before the pop
    assign o_desc  = entries[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_WID'(DESC_DEPTH));

endmodule

//--- hdl/packet_playback.sv
`timescale 1ns/1ps

module packet_playback import proxy_pkt_pkg::*; (
    input  logic      clk,
    input  logic      srst,
    input  logic      i_start,
    input  pkt_len_t  i_len,
    input  data_t     i_data_base,
    output pkt_word_t o_word,
    output logic      o_busy
);
    play_state_t state;
    pkt_len_t    len_q;
    data_t       base_q;
    pkt_len_t    idx;
    logic        emit_q;
    logic        sop_q;
    logic        eop_q;
    data_t       data_q;
    logic        accept;
    logic        last;

    // Start pulses are ignored while a packet is running
    assign accept = (state == PLAY_IDLE) && i_start;
    assign last   = (idx == len_q - 1'b1);

    always_ff @(posedge clk) begin
        if (srst) begin
            state  <= PLAY_IDLE;
            emit_q <= 1'b0;
        end else begin
            emit_q <= (state == PLAY_RUN);
            case (state)
                PLAY_IDLE: if (accept) state <= PLAY_RUN;
                PLAY_RUN:  if (last) state <= PLAY_IDLE;
                default:   state <= PLAY_IDLE;
            endcase
        end
    end

    // Word k of the packet carries base + k
    always_ff @(posedge clk) begin
        if (accept) begin
            len_q  <= i_len;
            base_q <= i_data_base;
            idx    <= '0;
        end else if (state == PLAY_RUN) begin
            idx <= idx + 1'b1;
        end
        sop_q  <= (idx == '0);
        eop_q  <= last;
        data_q <= base_q + data_t'(idx);
    end

    assign o_word = '{valid: emit_q, sop: sop_q, eop: eop_q, data: data_q};
    assign o_busy = emit_q;

endmodule

//--- hdl/packet_queue.sv
`timescale 1ns/1ps

module packet_queue import proxy_pkt_pkg::*; #(
    parameter int BUF_WORDS  = 128,
    parameter int DESC_DEPTH = 4
) (
    input  logic        clk,
    input  logic        srst,
    input  pkt_word_t   i_word,
    input  logic        i_capture_en,
    output pkt_word_t   o_word,
    output logic [15:0] o_drop_count
);
    localparam int ADDR_WID = $clog2(BUF_WORDS);
    // Extra bit tells a full buffer from an empty one
    localparam int PTR_WID  = ADDR_WID + 1;

    typedef logic [PTR_WID-1:0] ptr_t;

    data_t               mem [BUF_WORDS];
    ptr_t                wr_ptr;
    ptr_t                pkt_start;
    ptr_t                rel_ptr;
    pkt_len_t            pkt_cnt;
    logic                drop_q;
    ptr_t                used;
    logic                mem_full;
    ptr_t                start_eff;
    pkt_len_t            len_eff;
    logic                word_drop;
    desc_t               push_desc;
    desc_t               head_desc;
    logic                desc_push;
    logic                desc_pop;
    logic                desc_empty;
    logic                desc_full;
    rd_state_t           rd_state;
    logic [ADDR_WID-1:0] rd_addr;
    pkt_len_t            rd_left;
    logic                rd_issue;
    data_t               rd_data;
    logic                out_valid;
    logic                out_sop;
    logic                out_eop;

    // ----------------------------------------------------------------------
    // Write side
    // ----------------------------------------------------------------------
    always_comb begin
        used      = wr_ptr - rel_ptr;
        mem_full  = (used == ptr_t'(BUF_WORDS));
        start_eff = i_word.sop ? wr_ptr : pkt_start;
        len_eff   = (i_word.sop ? pkt_len_t'(0) : pkt_cnt) + 1'b1;
        // Once a word is lost the rest of the packet goes too
        word_drop = mem_full || (drop_q && !i_word.sop);
        push_desc = '{start_ptr: desc_ptr_t'(start_eff[ADDR_WID-1:0]), len: len_eff};
    end

    assign desc_push = i_word.valid && i_word.eop && !word_drop && !desc_full;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr       <= '0;
            pkt_start    <= '0;
            pkt_cnt      <= '0;
            drop_q       <= 1'b0;
            o_drop_count <= '0;
        end else if (i_word.valid) begin
            pkt_start <= start_eff;
            pkt_cnt   <= len_eff;
            drop_q    <= word_drop;
            if (i_word.eop && (word_drop || desc_full)) begin
                // Rewind over the packet, its space is free again
                wr_ptr       <= start_eff;
                o_drop_count <= o_drop_count + 1'b1;
            end else if (!word_drop) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Word memory, one write and one registered read port
    always_ff @(posedge clk) begin
        if (i_word.valid && !word_drop) mem[wr_ptr[ADDR_WID-1:0]] <= i_word.data;
        if (rd_issue) rd_data <= mem[rd_addr];
    end

    packet_desc_fifo #(
        .DESC_DEPTH ( DESC_DEPTH )
    ) i_packet_desc_fifo (
        .clk,
        .srst,
        .i_push  ( desc_push ),
        .i_desc  ( push_desc ),
        .i_pop   ( desc_pop ),
        .o_desc  ( head_desc ),
        .o_empty ( desc_empty ),
        .o_full  ( desc_full )
    );

    // ----------------------------------------------------------------------
    // Read side
    // ----------------------------------------------------------------------
    // Capture enable is only looked at between packets
    assign desc_pop = (rd_state == RD_IDLE) && i_capture_en && !desc_empty;
    assign rd_issue = (rd_state == RD_FETCH) || (rd_state == RD_STREAM);

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_state  <= RD_IDLE;
            rel_ptr   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_issue;
            case (rd_state)
                RD_IDLE:             if (desc_pop) rd_state <= RD_FETCH;
                RD_FETCH, RD_STREAM: rd_state <= (rd_left == 1) ? RD_IDLE : RD_STREAM;
                default:             rd_state <= RD_IDLE;
            endcase
            // Space frees as each word is read
            if (rd_issue) rel_ptr <= rel_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (desc_pop) begin
            rd_addr <= head_desc.start_ptr[ADDR_WID-1:0];
            rd_left <= head_desc.len;
        end else if (rd_issue) begin
            rd_addr <= rd_addr + 1'b1;
            rd_left <= rd_left - 1'b1;
        end
        out_sop <= (rd_state == RD_FETCH);
        out_eop <= (rd_left == 1);
    end

    assign o_word = '{valid: out_valid, sop: out_sop, eop: out_eop, data: rd_data};

endmodule

//--- hdl/proxy_pkt_pkg.sv
package proxy_pkt_pkg;

    // ----------------------------------------------------------------------
    // Word and packet sizes
    // ----------------------------------------------------------------------
    localparam int WORD_WID      = 32;
    localparam int MAX_PKT_WORDS = 64;

    // Holds 1 to MAX_PKT_WORDS inclusive
    localparam int PKT_LEN_WID   = $clog2(MAX_PKT_WORDS + 1);

    // Covers buffer depths up to 256 words
    localparam int DESC_PTR_WID  = 8;

    typedef logic [WORD_WID-1:0]     data_t;
    typedef logic [PKT_LEN_WID-1:0]  pkt_len_t;
    typedef logic [DESC_PTR_WID-1:0] desc_ptr_t;

    // ----------------------------------------------------------------------
    // Packet word and statistics
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic  valid;
        logic  sop;
        logic  eop;
        data_t data;
    } pkt_word_t;

    typedef struct packed {
        logic [15:0] pkt_count;
        logic [23:0] word_count;
        data_t       checksum;
        pkt_len_t    last_len;
    } capture_stats_t;

    // One stored packet in the queue memory
    typedef struct packed {
        desc_ptr_t start_ptr;
        pkt_len_t  len;
    } desc_t;

    typedef enum logic {
        PLAY_IDLE,
        PLAY_RUN
    } play_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_STREAM
    } rd_state_t;

endpackage

//--- hdl/proxy_pkt_top.sv
`timescale 1ns/1ps

module proxy_pkt_top import proxy_pkt_pkg::*; #(
    parameter int BUF_WORDS  = 128,
    parameter int DESC_DEPTH = 4
) (
    input  logic           clk,
    input  logic           srst,
    input  logic           i_start,
    input  pkt_len_t       i_len,
    input  data_t          i_data_base,
    input  logic           i_capture_en,
    output logic           o_play_busy,
    output capture_stats_t o_stats,
    output logic [15:0]    o_drop_count
);
    pkt_word_t play_word;
    pkt_word_t cap_word;

    // ----------------------------------------------------------------------
    // Producer, buffer and consumer
    // ----------------------------------------------------------------------
    packet_playback i_packet_playback (
        .clk,
        .srst,
        .i_start,
        .i_len,
        .i_data_base,
        .o_word ( play_word ),
        .o_busy ( o_play_busy )
    );

    packet_queue #(
        .BUF_WORDS  ( BUF_WORDS ),
        .DESC_DEPTH ( DESC_DEPTH )
    ) i_packet_queue (
        .clk,
        .srst,
        .i_word       ( play_word ),
        .i_capture_en,
        .o_word       ( cap_word ),
        .o_drop_count
    );

    packet_capture i_packet_capture (
        .clk,
        .srst,
        .i_word  ( cap_word ),
        .o_stats
    );

endmodule

//--- proxy_pkt.f
hdl/proxy_pkt_pkg.sv
hdl/packet_playback.sv
hdl/packet_desc_fifo.sv
hdl/packet_queue.sv
hdl/packet_capture.sv
hdl/proxy_pkt_top.sv
verification/proxy_pkt_checker.sv
verification/proxy_pkt_tb.sv

//--- verification/proxy_pkt_checker.sv
`timescale 1ns/1ps

module proxy_pkt_checker import proxy_pkt_pkg::*; (
    input logic           clk,
    input logic           srst,
    input pkt_word_t      i_cap_word,
    input logic           i_play_busy,
    input capture_stats_t i_stats
);
    logic pkt_open;

    // High between a captured sop and its eop
    always_ff @(posedge clk) begin
        if (srst) begin
            pkt_open <= 1'b0;
        end else if (i_cap_word.valid) begin
            pkt_open <= !i_cap_word.eop;
        end
    end

    // ----------------------------------------------------------------------
    // Properties
    // ----------------------------------------------------------------------
    sop_in_open_pkt: assert property (
        @(posedge clk) disable iff (srst)
        (i_cap_word.valid && i_cap_word.sop) |-> !pkt_open
    ) else $error("sop on cap_word while a packet is still open");

    busy_after_reset: assert property (
        @(posedge clk) ($past(srst) && !srst) |-> !i_play_busy
    ) else $error("o_play_busy high in the cycle after reset");

    pkt_count_monotonic: assert property (
        @(posedge clk) disable iff (srst)
        !$past(srst) |-> (i_stats.pkt_count >= $past(i_stats.pkt_count))
    ) else $error("o_stats.pkt_count decreased");

endmodule

bind proxy_pkt_top proxy_pkt_checker u_proxy_pkt_checker (
    .clk         ( clk ),
    .srst        ( srst ),
    .i_cap_word  ( cap_word ),
    .i_play_busy ( o_play_busy ),
    .i_stats     ( o_stats )
);

//--- verification/proxy_pkt_tb.sv
`timescale 1ns/1ps

module proxy_pkt_tb import proxy_pkt_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT   = 1000;
    // Packets sent over all tests, each bounded by write plus readout time
    localparam int TOTAL_PKTS      = 25;
    localparam int PKT_CYCLES      = 2 * MAX_PKT_WORDS + 20;
    localparam int TEST_CYCLES     = TOTAL_PKTS * PKT_CYCLES + 6 * (RESET_CYCLES + 12);
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

    logic           clk = 1'b0;
    logic           srst;
    logic           i_start;
    pkt_len_t       i_len;
    data_t          i_data_base;
    logic           i_capture_en;
    logic           o_play_busy;
    capture_stats_t o_stats;
    logic [15:0]    o_drop_count;

    // Reference model state
    capture_stats_t exp_stats;
    logic [15:0]    exp_drops;
    logic [31:0]    lcg_state = 32'd77992;
    int             error_count  = 0;
    int             test_count   = 0;
    int             failed_tests = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    proxy_pkt_top #(
        .BUF_WORDS  ( 128 ),
        .DESC_DEPTH ( 4 )
    ) uut (
        .clk,
        .srst,
        .i_start,
        .i_len,
        .i_data_base,
        .i_capture_en,
        .o_play_busy,
        .o_stats,
        .o_drop_count
    );

    // ----------------------------------------------------------------------
    // Stimulus and model helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        srst         <= 1'b1;
        i_start      <= 1'b0;
        i_capture_en <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        srst      <= 1'b0;
        exp_stats = '0;
        exp_drops = '0;
    endtask

    task automatic send_packet(input pkt_len_t len, input data_t base);
        @(posedge clk);
        i_start     <= 1'b1;
        i_len       <= len;
        i_data_base <= base;
        @(posedge clk);
        i_start <= 1'b0;
    endtask

    // Expected stats for one packet that reaches capture
    task automatic model_add(input pkt_len_t len, input data_t base);
        for (int k = 0; k < int'(len); k++) begin
            exp_stats.checksum = exp_stats.checksum + base + data_t'(k);
        end
        exp_stats.word_count = exp_stats.word_count + 24'(len);
        exp_stats.pkt_count  = exp_stats.pkt_count + 16'd1;
        exp_stats.last_len   = len;
    endtask

    // Busy rises one cycle after the start is taken, so see it high first
    // Busy stays high for one cycle per packet word
    task automatic wait_play_idle(input int exp_high);
        int n    = 0;
        int high = 0;
        @(negedge clk);
        while (o_play_busy !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        while (o_play_busy === 1'b1 && n < WAIT_LIMIT) begin
            high++;
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Playback did not finish within %0d cycles", WAIT_LIMIT);
            error_count++;
        end else begin
            compare_count("o_play_busy high cycles", 16'(high), 16'(exp_high));
        end
    endtask

    task automatic wait_pkt_count(input logic [15:0] target);
        int n = 0;
        while (o_stats.pkt_count !== target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (o_stats.pkt_count !== target) begin
            $display("Packet count did not reach %0d within %0d cycles", target, WAIT_LIMIT);
            error_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic compare_stats(input capture_stats_t got, input capture_stats_t exp);
        if (got.pkt_count !== exp.pkt_count) begin
            $display("mismatch o_stats.pkt_count: got 0x%h, expected 0x%h",
                     got.pkt_count, exp.pkt_count);
            error_count++;
        end
        if (got.word_count !== exp.word_count) begin
            $display("mismatch o_stats.word_count: got 0x%h, expected 0x%h",
                     got.word_count, exp.word_count);
            error_count++;
        end
        if (got.checksum !== exp.checksum) begin
            $display("mismatch o_stats.checksum: got 0x%h, expected 0x%h",
                     got.checksum, exp.checksum);
            error_count++;
        end
        if (got.last_len !== exp.last_len) begin
            $display("mismatch o_stats.last_len: got 0x%h, expected 0x%h",
                     got.last_len, exp.last_len);
            error_count++;
        end
    endtask

    task automatic compare_count(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_single_packet();
        int errs = error_count;
        apply_reset();
        i_capture_en <= 1'b1;
        send_packet(pkt_len_t'(5), 32'h100);
        model_add(pkt_len_t'(5), 32'h100);
        wait_play_idle(5);
        wait_pkt_count(exp_stats.pkt_count);
        compare_stats(o_stats, exp_stats);
        compare_count("o_drop_count", o_drop_count, exp_drops);
        report_test("single packet", errs);
    endtask

    task automatic test_buffered_order();
        int       errs = error_count;
        pkt_len_t lens [3] = '{pkt_len_t'(3), pkt_len_t'(7), pkt_len_t'(4)};
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            send_packet(lens[i], data_t'((i + 1) * 32'h1000));
            model_add(lens[i], data_t'((i + 1) * 32'h1000));
            wait_play_idle(int'(lens[i]));
        end
        // Nothing may leave the queue yet
        compare_count("o_stats.pkt_count", o_stats.pkt_count, 16'd0);
        @(posedge clk);
        i_capture_en <= 1'b1;
        wait_pkt_count(exp_stats.pkt_count);
        compare_stats(o_stats, exp_stats);
        compare_count("o_drop_count", o_drop_count, exp_drops);
        report_test("buffered order", errs);
    endtask

    task automatic test_memory_drop();
        int errs = error_count;
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            send_packet(pkt_len_t'(60), data_t'((i + 1) * 32'h10000));
            // Third packet runs out of memory space
            if (i < 2) model_add(pkt_len_t'(60), data_t'((i + 1) * 32'h10000));
            wait_play_idle(60);
        end
        exp_drops = 16'd1;
        compare_count("o_drop_count", o_drop_count, exp_drops);
        @(posedge clk);
        i_capture_en <= 1'b1;
        wait_pkt_count(exp_stats.pkt_count);
        compare_stats(o_stats, exp_stats);
        report_test("memory overflow drop", errs);
    endtask

    task automatic test_desc_drop();
        int errs = error_count;
        apply_reset();
        for (int i = 0; i < 6; i++) begin
            send_packet(pkt_len_t'(2), data_t'(32'h500 + i * 16));
            if (i < 4) model_add(pkt_len_t'(2), data_t'(32'h500 + i * 16));
            wait_play_idle(2);
        end
        exp_drops = 16'd2;
        compare_count("o_drop_count", o_drop_count, exp_drops);
        @(posedge clk);
        i_capture_en <= 1'b1;
        wait_pkt_count(exp_stats.pkt_count);
        compare_stats(o_stats, exp_stats);
        report_test("descriptor overflow drop", errs);
    endtask

    task automatic test_start_while_busy();
        int errs = error_count;
        apply_reset();
        i_capture_en <= 1'b1;
        send_packet(pkt_len_t'(5), 32'h200);
        // Lands two cycles after the first start
        send_packet(pkt_len_t'(3), 32'h900);
        model_add(pkt_len_t'(5), 32'h200);
        // First busy cycle passes while the second start is driven
        wait_play_idle(4);
        wait_pkt_count(exp_stats.pkt_count);
        // Let any stray packet drain
        repeat (10) @(negedge clk);
        compare_stats(o_stats, exp_stats);
        compare_count("o_drop_count", o_drop_count, exp_drops);
        report_test("start while busy", errs);
    endtask

    task automatic test_random_lengths();
        int          errs = error_count;
        logic [31:0] r;
        pkt_len_t    len;
        data_t       base;
        apply_reset();
        i_capture_en <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            r    = lcg_next();
            len  = pkt_len_t'(r[21:16]) + 1'b1;
            base = lcg_next();
            send_packet(len, base);
            model_add(len, base);
            wait_play_idle(int'(len));
            wait_pkt_count(exp_stats.pkt_count);
        end
        compare_stats(o_stats, exp_stats);
        compare_count("o_drop_count", o_drop_count, exp_drops);
        report_test("random lengths", errs);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        srst         = 1'b1;
        i_start      = 1'b0;
        i_len        = '0;
        i_data_base  = '0;
        i_capture_en = 1'b0;
        test_single_packet();
        test_buffered_order();
        test_memory_drop();
        test_desc_drop();
        test_start_while_busy();
        test_random_lengths();
        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule
